/* source/aes_clear_consts.svh */
// Secure-wipe subsystem constants
// Widths of the clearing PRNG seed, the entropy port and the key register

`ifndef AES_CLEAR_CONSTS_SVH
`define AES_CLEAR_CONSTS_SVH

// LFSR state and seed width, also the width of one key word
`define CLR_WIDTH 64

// Bits delivered per entropy transfer
// Half the seed width, so one reseed takes two transfers
`define CLR_ENT_WIDTH 32

// Words per key share
`define CLR_KEY_WORDS 4

`endif

/* source/clr_prng_pkg.sv */
// Clearing PRNG definitions
// State and share types, LFSR reset seed and feedback mask,
// bit permutations around the non-linear layer and the PRINCE S-box

`include "aes_clear_consts.svh"

package clr_prng_pkg;

  // One LFSR state or one PRNG output word
  typedef logic [`CLR_WIDTH-1:0] clr_state_t;

  // PRNG output
  // Share 1 is a fixed permutation of share 0
  typedef struct packed {
    clr_state_t share0;
    clr_state_t share1;
  } clr_shares_t;

  // Entry i names the source bit of output bit i
  typedef logic [$clog2(`CLR_WIDTH)-1:0] clr_perm_t [`CLR_WIDTH];

  typedef logic [3:0] clr_sbox_t [16];

  // Must not be zero or the LFSR locks up
  parameter clr_state_t CLR_LFSR_SEED = 64'h3C5A_96E1_7B08_D24F;

  // Right-shifting Galois mask for x^64 + x^63 + x^61 + x^60 + 1
  parameter clr_state_t CLR_LFSR_TAPS = 64'hD800_0000_0000_0000;

  // Applied to the raw state ahead of the S-box layer
  parameter clr_perm_t CLR_STATE_PERM_IN = '{
     7, 20, 33, 46, 59,  8, 21, 34, 47, 60,  9, 22, 35, 48, 61, 10,
    23, 36, 49, 62, 11, 24, 37, 50, 63, 12, 25, 38, 51,  0, 13, 26,
    39, 52,  1, 14, 27, 40, 53,  2, 15, 28, 41, 54,  3, 16, 29, 42,
    55,  4, 17, 30, 43, 56,  5, 18, 31, 44, 57,  6, 19, 32, 45, 58
  };

  // Spreads each S-box nibble across the output word
  parameter clr_perm_t CLR_STATE_PERM_OUT = '{
    11, 34, 57, 16, 39, 62, 21, 44,  3, 26, 49,  8, 31, 54, 13, 36,
    59, 18, 41,  0, 23, 46,  5, 28, 51, 10, 33, 56, 15, 38, 61, 20,
    43,  2, 25, 48,  7, 30, 53, 12, 35, 58, 17, 40, 63, 22, 45,  4,
    27, 50,  9, 32, 55, 14, 37, 60, 19, 42,  1, 24, 47,  6, 29, 52
  };

  // Derives the second share from the first
  parameter clr_perm_t CLR_SHARE_PERM = '{
    29,  2, 39, 12, 49, 22, 59, 32,  5, 42, 15, 52, 25, 62, 35,  8,
    45, 18, 55, 28,  1, 38, 11, 48, 21, 58, 31,  4, 41, 14, 51, 24,
    61, 34,  7, 44, 17, 54, 27,  0, 37, 10, 47, 20, 57, 30,  3, 40,
    13, 50, 23, 60, 33,  6, 43, 16, 53, 26, 63, 36,  9, 46, 19, 56
  };

  // PRINCE 4-bit S-box
  parameter clr_sbox_t CLR_SBOX = '{
    4'hB, 4'hF, 4'h3, 4'h2, 4'hA, 4'hC, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'hE, 4'h5, 4'hD, 4'h4
  };

endpackage

/* source/clr_key_pkg.sv */
// Key register definitions
// Word and two-share layout of the AES key register that the wipe clears

`include "aes_clear_consts.svh"

package clr_key_pkg;

  // One key word, as wide as a PRNG output word
  typedef logic [`CLR_WIDTH-1:0] key_word_t;

  // Both shares of the key
  // Word 0 sits in the low bits of each share
  typedef struct packed {
    key_word_t [`CLR_KEY_WORDS-1:0] sh0;
    key_word_t [`CLR_KEY_WORDS-1:0] sh1;
  } key_shares_t;

endpackage

/* source/clr_lfsr.sv */
// Reseedable Galois LFSR for the clearing PRNG
// The state passes through a bit permutation, a PRINCE S-box layer
// and a second permutation before it leaves the block

`timescale 1ns/1ps

`include "aes_clear_consts.svh"

module clr_lfsr (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     seed_en_i,
  input  clr_prng_pkg::clr_state_t seed_i,
  input  logic                     lfsr_en_i,
  output clr_prng_pkg::clr_state_t state_o
);

  import clr_prng_pkg::*;

  clr_state_t lfsr_q;
  clr_state_t lfsr_d;
  clr_state_t perm_in;
  clr_state_t sbox_out;

  // Next state
  // A seed load wins over a step
  always_comb begin
    lfsr_d = lfsr_q;
    if (seed_en_i) begin
      lfsr_d = seed_i;
    end else if (lfsr_en_i) begin
      // Shift right and fold the dropped bit back in through the taps
      lfsr_d = {1'b0, lfsr_q[`CLR_WIDTH-1:1]};
      if (lfsr_q[0]) begin
        lfsr_d = lfsr_d ^ CLR_LFSR_TAPS;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= CLR_LFSR_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  // Permutation ahead of the S-boxes
  for (genvar i = 0; i < `CLR_WIDTH; i++) begin : gen_perm_in
    assign perm_in[i] = lfsr_q[CLR_STATE_PERM_IN[i]];
  end

  // Non-linear layer, one S-box per nibble
  for (genvar n = 0; n < `CLR_WIDTH / 4; n++) begin : gen_sbox
    assign sbox_out[4*n +: 4] = CLR_SBOX[perm_in[4*n +: 4]];
  end

  // Output permutation
  for (genvar i = 0; i < `CLR_WIDTH; i++) begin : gen_perm_out
    assign state_o[i] = sbox_out[CLR_STATE_PERM_OUT[i]];
  end

  // All-zero state would lock the generator on a constant output
  a_state_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    lfsr_q != '0
  ) else $error("LFSR state reached zero");

  // Reseed arbitration upstream keeps loads and steps apart
  a_no_seed_while_step: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(seed_en_i && lfsr_en_i)
  ) else $error("LFSR seed load during a step request");

endmodule

/* source/clr_prng.sv */
// Clearing PRNG
// Serves wipe data from the LFSR with reseed requests first
// Two entropy transfers build one seed
// Share 1 is a fixed permutation of share 0

`timescale 1ns/1ps

`include "aes_clear_consts.svh"

module clr_prng (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      data_req_i,
  output logic                      data_ack_o,
  output clr_prng_pkg::clr_shares_t data_o,
  input  logic                      reseed_req_i,
  output logic                      reseed_ack_o,
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [`CLR_ENT_WIDTH-1:0] entropy_i
);

  import clr_prng_pkg::*;

  logic                      ent_xfer;
  logic                      seed_valid;
  logic                      lfsr_en;
  clr_state_t                seed;
  clr_state_t                share0;
  logic [`CLR_ENT_WIDTH-1:0] buf_q;
  logic                      buf_valid_q;

  // Data requests wait while any reseed is pending
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;
  // Step only on a consumed word
  assign lfsr_en    = data_req_i & data_ack_o;

  // Entropy is requested for as long as the reseed is
  assign entropy_req_o = reseed_req_i;
  assign ent_xfer      = entropy_req_o & entropy_ack_i;

  // Valid flag flips on every transfer
  // Set after the first half, cleared when the seed completes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (ent_xfer) begin
      buf_valid_q <= ~buf_valid_q;
    end
  end

  // Upper seed half, captured from the first transfer only
  always_ff @(posedge clk_i) begin
    if (ent_xfer && !buf_valid_q) begin
      buf_q <= entropy_i;
    end
  end

  // Second transfer completes the seed in the same cycle
  assign seed         = {buf_q, entropy_i};
  assign seed_valid   = buf_valid_q & ent_xfer;
  assign reseed_ack_o = seed_valid;

  clr_lfsr u_clr_lfsr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .seed_en_i (seed_valid),
    .seed_i    (seed),
    .lfsr_en_i (lfsr_en),
    .state_o   (share0)
  );

  assign data_o.share0 = share0;

  // Second share for clearing the other half of masked registers
  for (genvar i = 0; i < `CLR_WIDTH; i++) begin : gen_share_perm
    assign data_o.share1[i] = share0[CLR_SHARE_PERM[i]];
  end

  // Every bit position must be hit exactly once
  initial begin : p_share_perm_check
    logic [`CLR_WIDTH-1:0] seen;
    seen = '0;
    for (int k = 0; k < `CLR_WIDTH; k++) begin
      seen[CLR_SHARE_PERM[k]] = 1'b1;
    end
    assert (&seen) else $error("CLR_SHARE_PERM is not a permutation");
  end

  a_no_data_during_reseed: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    reseed_req_i |-> !data_ack_o
  ) else $error("Data ack while reseed pending");

  // Seed completion must never repeat on the following cycle
  a_reseed_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    reseed_ack_o |=> !reseed_ack_o
  ) else $error("Reseed ack longer than one cycle");

endmodule

/* source/clr_key_wipe.sv */
// Two-share key register with secure wipe
// Loads a key from outside or overwrites both shares word by word
// with PRNG output when a wipe is requested

`timescale 1ns/1ps

`include "aes_clear_consts.svh"

module clr_key_wipe (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      key_we_i,
  input  clr_key_pkg::key_shares_t  key_i,
  input  logic                      wipe_req_i,
  output logic                      wipe_ack_o,
  output logic                      prng_req_o,
  input  logic                      prng_ack_i,
  input  clr_prng_pkg::clr_shares_t prng_data_i,
  output clr_key_pkg::key_shares_t  key_o
);

  import clr_key_pkg::*;

  localparam int unsigned          idx_w    = $clog2(`CLR_KEY_WORDS);
  localparam logic [idx_w-1:0]     last_idx = idx_w'(`CLR_KEY_WORDS - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_wipe,
    st_done
  } wipe_state_e;

  wipe_state_e      state_q;
  logic [idx_w-1:0] word_q;
  logic             word_take;
  key_shares_t      key_q;

  // One PRNG word per cycle while wiping
  assign prng_req_o = (state_q == st_wipe);
  assign word_take  = prng_req_o & prng_ack_i;
  // Ack in the cycle after the last word lands
  assign wipe_ack_o = (state_q == st_done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      word_q  <= '0;
      key_q   <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          // External loads only outside a wipe
          if (key_we_i) begin
            key_q <= key_i;
          end
          if (wipe_req_i) begin
            state_q <= st_wipe;
            word_q  <= '0;
          end
        end
        st_wipe: begin
          // Index holds under back-pressure
          if (word_take) begin
            key_q.sh0[word_q] <= prng_data_i.share0;
            key_q.sh1[word_q] <= prng_data_i.share1;
            word_q            <= word_q + 1'b1;
            if (word_q == last_idx) begin
              state_q <= st_done;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign key_o = key_q;

  a_wipe_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wipe_ack_o |=> !wipe_ack_o
  ) else $error("Wipe ack longer than one cycle");

  // Stalled request keeps its word slot
  a_prng_req_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    prng_req_o && !prng_ack_i |=> prng_req_o && $stable(word_q)
  ) else $error("PRNG request dropped before ack");

endmodule

/* source/clr_wipe_top.sv */
// Secure-wipe subsystem top level
// Key register with wipe controller, fed by the reseedable clearing PRNG

`timescale 1ns/1ps

`include "aes_clear_consts.svh"

module clr_wipe_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      key_we_i,
  input  clr_key_pkg::key_shares_t  key_i,
  input  logic                      wipe_req_i,
  output logic                      wipe_ack_o,
  input  logic                      reseed_req_i,
  output logic                      reseed_ack_o,
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [`CLR_ENT_WIDTH-1:0] entropy_i,
  output clr_key_pkg::key_shares_t  key_o
);

  import clr_prng_pkg::*;

  // Wipe controller to PRNG
  logic        prng_req;
  logic        prng_ack;
  clr_shares_t prng_data;

  clr_key_wipe u_clr_key_wipe (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .key_we_i    (key_we_i),
    .key_i       (key_i),
    .wipe_req_i  (wipe_req_i),
    .wipe_ack_o  (wipe_ack_o),
    .prng_req_o  (prng_req),
    .prng_ack_i  (prng_ack),
    .prng_data_i (prng_data),
    .key_o       (key_o)
  );

  clr_prng u_clr_prng (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (prng_req),
    .data_ack_o    (prng_ack),
    .data_o        (prng_data),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i)
  );

endmodule

/* dv/clr_model.svh */
// Reference model of the clearing PRNG
// LFSR step, permutation and S-box layer, and the share 1 permutation

`ifndef CLR_MODEL_SVH
`define CLR_MODEL_SVH

// Right-shifting Galois step
// The dropped bit folds back in through the taps
function automatic clr_state_t lfsr_next(input clr_state_t s);
  clr_state_t n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ CLR_LFSR_TAPS;
  end
  return n;
endfunction

// Output bit i takes source bit perm[i]
function automatic clr_state_t permute_bits(input clr_state_t s, input clr_perm_t perm);
  clr_state_t p;
  for (int i = 0; i < `CLR_WIDTH; i++) begin
    p[i] = s[perm[i]];
  end
  return p;
endfunction

// One S-box per nibble
function automatic clr_state_t sbox_layer(input clr_state_t s);
  clr_state_t o;
  for (int n = 0; n < `CLR_WIDTH / 4; n++) begin
    o[4*n +: 4] = CLR_SBOX[s[4*n +: 4]];
  end
  return o;
endfunction

// Share 0 seen by the key register for a given LFSR state
function automatic clr_state_t prng_word(input clr_state_t s);
  return permute_bits(sbox_layer(permute_bits(s, CLR_STATE_PERM_IN)), CLR_STATE_PERM_OUT);
endfunction

// Share 1 derived from share 0
function automatic clr_state_t share1_of(input clr_state_t w);
  return permute_bits(w, CLR_SHARE_PERM);
endfunction

`endif

/* dv/tb_clr_wipe.sv */
// Testbench for the secure-wipe subsystem
// Random loads, wipes and reseeds checked every cycle against a reference model

`timescale 1ns/1ps

`include "aes_clear_consts.svh"

module tb_clr_wipe;

  import clr_prng_pkg::*;
  import clr_key_pkg::*;

  `include "clr_model.svh"

  localparam int clk_period = 8;
  localparam int drive_dly  = 1;
  localparam int max_wait   = 64;
  localparam int n_mix      = 120;
  // Fixed cycle budget per directed or random operation
  localparam int total_ops   = n_mix + 10;
  localparam int op_cycles   = 80;
  localparam int watchdog_ns = total_ops * op_cycles * clk_period;
  localparam int idx_w       = $clog2(`CLR_KEY_WORDS);

  typedef logic [$bits(key_shares_t)-1:0] cmp_t;
  typedef enum int {ph_idle, ph_wipe, ph_done} wipe_phase_e;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      key_we_i;
  key_shares_t               key_i;
  logic                      wipe_req_i;
  logic                      wipe_ack_o;
  logic                      reseed_req_i;
  logic                      reseed_ack_o;
  logic                      entropy_req_o;
  logic                      entropy_ack_i;
  logic [`CLR_ENT_WIDTH-1:0] entropy_i;
  key_shares_t               key_o;

  // Reference model state
  wipe_phase_e               m_phase;
  logic [idx_w-1:0]          m_idx;
  key_shares_t               m_key;
  clr_state_t                m_lfsr;
  clr_state_t                m_word;
  logic [`CLR_ENT_WIDTH-1:0] m_buf;
  logic                      m_buf_valid;
  logic                      m_seed_done;

  logic [31:0] rng_state;
  int          check_cnt;
  int          value_err_cnt;
  int          other_err_cnt;

  clr_wipe_top u_clr_wipe_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .key_we_i      (key_we_i),
    .key_i         (key_i),
    .wipe_req_i    (wipe_req_i),
    .wipe_ack_o    (wipe_ack_o),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .key_o         (key_o)
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  task automatic check_value(input string name, input cmp_t got, input cmp_t exp);
    check_cnt++;
    if (got !== exp) begin
      value_err_cnt++;
      $display("Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // 32-bit xorshift
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic key_shares_t random_key();
    key_shares_t k;
    for (int i = 0; i < $bits(key_shares_t) / 32; i++) begin
      k[32*i +: 32] = next_rand();
    end
    return k;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic load_key();
    @(posedge clk_i);
    #drive_dly;
    key_we_i = 1'b1;
    key_i    = random_key();
    @(posedge clk_i);
    #drive_dly;
    key_we_i = 1'b0;
  endtask

  // Latency only holds when no reseed stalls the wipe
  task automatic wipe_key(input bit check_latency);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    #drive_dly;
    wipe_req_i = 1'b1;
    @(negedge clk_i);
    while (!wipe_ack_o && cycles < max_wait) begin
      cycles++;
      @(negedge clk_i);
    end
    if (!wipe_ack_o) begin
      other_err_cnt++;
      $display("Timed out at %0t waiting for wipe_ack_o", $time);
    end else if (check_latency) begin
      check_value("wipe_ack_o latency", cmp_t'(cycles), cmp_t'(5));
    end
    @(posedge clk_i);
    #drive_dly;
    wipe_req_i = 1'b0;
  endtask

  // Random gaps on the entropy source in about one cycle of four
  task automatic drive_entropy();
    entropy_ack_i = (next_rand() % 4) != 0;
    entropy_i     = next_rand();
  endtask

  task automatic reseed_prng();
    int xfers;
    int cycles;
    bit acked;
    xfers  = 0;
    cycles = 0;
    acked  = 1'b0;
    @(posedge clk_i);
    #drive_dly;
    reseed_req_i = 1'b1;
    drive_entropy();
    @(negedge clk_i);
    while (!acked && cycles < max_wait) begin
      if (entropy_req_o && entropy_ack_i) begin
        xfers++;
      end
      if (reseed_ack_o) begin
        acked = 1'b1;
      end else begin
        cycles++;
        @(posedge clk_i);
        #drive_dly;
        drive_entropy();
        @(negedge clk_i);
      end
    end
    if (!acked) begin
      other_err_cnt++;
      $display("Timed out at %0t waiting for reseed_ack_o", $time);
    end else begin
      check_value("entropy transfers", cmp_t'(xfers), cmp_t'(2));
    end
    @(posedge clk_i);
    #drive_dly;
    reseed_req_i  = 1'b0;
    entropy_ack_i = 1'b0;
  endtask

  // Cycle model sampled mid-cycle once inputs and outputs are settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      m_phase     = ph_idle;
      m_idx       = '0;
      m_key       = '0;
      m_lfsr      = CLR_LFSR_SEED;
      m_buf_valid = 1'b0;
    end else begin
      m_seed_done = reseed_req_i && entropy_ack_i && m_buf_valid;
      check_value("key_o", cmp_t'(key_o), cmp_t'(m_key));
      check_value("wipe_ack_o", cmp_t'(wipe_ack_o), cmp_t'(m_phase == ph_done));
      check_value("entropy_req_o", cmp_t'(entropy_req_o), cmp_t'(reseed_req_i));
      check_value("reseed_ack_o", cmp_t'(reseed_ack_o), cmp_t'(m_seed_done));
      case (m_phase)
        ph_idle: begin
          if (key_we_i) begin
            m_key = key_i;
          end
          if (wipe_req_i) begin
            m_phase = ph_wipe;
            m_idx   = '0;
          end
        end
        ph_wipe: begin
          // Pending reseed holds the wipe back
          if (!reseed_req_i) begin
            m_word            = prng_word(m_lfsr);
            m_key.sh0[m_idx]  = m_word;
            m_key.sh1[m_idx]  = share1_of(m_word);
            m_lfsr            = lfsr_next(m_lfsr);
            if (m_idx == idx_w'(`CLR_KEY_WORDS - 1)) begin
              m_phase = ph_done;
            end
            m_idx = m_idx + 1'b1;
          end
        end
        default: m_phase = ph_idle;
      endcase
      // First transfer is the upper seed half
      if (reseed_req_i && entropy_ack_i) begin
        if (m_buf_valid) begin
          m_lfsr      = {m_buf, entropy_i};
          m_buf_valid = 1'b0;
        end else begin
          m_buf       = entropy_i;
          m_buf_valid = 1'b1;
        end
      end
    end
  end

  initial begin : p_watchdog
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("Checks %0d, value errors %0d, other errors %0d",
             check_cnt, value_err_cnt, other_err_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : p_main
    int sel;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    key_we_i      = 1'b0;
    key_i         = '0;
    wipe_req_i    = 1'b0;
    reseed_req_i  = 1'b0;
    entropy_ack_i = 1'b0;
    entropy_i     = '0;
    rng_state     = 32'h4038;
    check_cnt     = 0;
    value_err_cnt = 0;
    other_err_cnt = 0;

    repeat (4) @(posedge clk_i);
    #drive_dly;
    rst_ni = 1'b1;

    // Reset values
    @(negedge clk_i);
    check_value("key_o after reset", cmp_t'(key_o), '0);
    check_value("wipe_ack_o after reset", cmp_t'(wipe_ack_o), '0);
    check_value("reseed_ack_o after reset", cmp_t'(reseed_ack_o), '0);
    check_value("entropy_req_o after reset", cmp_t'(entropy_req_o), '0);

    load_key();
    load_key();
    wipe_key(1'b1);
    wipe_key(1'b1);

    // Load during a wipe must be dropped
    fork
      wipe_key(1'b1);
      begin
        idle_cycles(2);
        load_key();
      end
    join

    reseed_prng();
    wipe_key(1'b1);

    // Reseed lands in the middle of a wipe
    fork
      wipe_key(1'b0);
      begin
        idle_cycles(2);
        reseed_prng();
      end
    join
    load_key();

    for (int op = 0; op < n_mix; op++) begin
      sel = int'(next_rand() % 6);
      case (sel)
        0: load_key();
        1, 2: wipe_key(1'b1);
        3: reseed_prng();
        4: begin
          fork
            wipe_key(1'b0);
            begin
              idle_cycles(int'(next_rand() % 4));
              reseed_prng();
            end
          join
        end
        default: begin
          fork
            wipe_key(1'b1);
            begin
              idle_cycles(1 + int'(next_rand() % 3));
              load_key();
            end
          join
        end
      endcase
      idle_cycles(int'(next_rand() % 3));
    end

    idle_cycles(4);
    $display("Checks %0d, value errors %0d, other errors %0d",
             check_cnt, value_err_cnt, other_err_cnt);
    if (value_err_cnt == 0 && other_err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* aes_clear.f */
+incdir+source
+incdir+dv
source/clr_prng_pkg.sv
source/clr_key_pkg.sv
source/clr_lfsr.sv
source/clr_prng.sv
source/clr_key_wipe.sv
source/clr_wipe_top.sv
dv/tb_clr_wipe.sv

/* Makefile */
# Verilator build and run for the secure-wipe subsystem

TOP := tb_clr_wipe
OBJ := obj_dir

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f aes_clear.f -Mdir $(OBJ)

# Run and decide the result from the log
run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@grep -q "TEST RESULT: PASS" sim.log || \
		(echo "Simulation did not pass, see sim.log" && exit 1)

clean:
	rm -rf $(OBJ) sim.log
